// File: hw/shouse_pkg.sv
// shared types for the two-CPU shared-bus mapper
// cpu bus request, address views, mapper register indices
// and the region codes of the 22-bit physical space

`default_nettype none

package shouse_pkg;

    // one CPU's bus request as seen by the mapper
    typedef struct packed {
        logic [15:0] addr;
        logic [ 7:0] dout;
        logic        rnw;   // 1 = read
        logic        vma;   // valid memory cycle
    } cpu_bus_t;            // 26 bits

    // memory view, bank select plus offset inside the 8 KB bank
    typedef struct packed {
        logic [ 2:0] bank_sel;  // addr 15:13
        logic [12:0] offset;
    } cpu_mem_view_t;

    // register view, used only for writes into the top window
    typedef struct packed {
        logic [2:0] window;     // 7 = mapper registers
        logic [3:0] reg_idx;    // addr 12:9
        logic [7:0] unused;
        logic       hi_bit;     // addr 0, becomes bank bit 8
    } cpu_reg_view_t;

    // same address word, two decodings
    typedef union packed {
        cpu_mem_view_t mem;
        cpu_reg_view_t regs;
    } cpu_addr_u;

    // mapper register indices
    localparam logic [3:0] REG_BANK0     = 4'd0;
    localparam logic [3:0] REG_BANK1     = 4'd1;
    localparam logic [3:0] REG_BANK2     = 4'd2;
    localparam logic [3:0] REG_BANK3     = 4'd3;
    localparam logic [3:0] REG_BANK4     = 4'd4;
    localparam logic [3:0] REG_BANK5     = 4'd5;
    localparam logic [3:0] REG_BANK6     = 4'd6;
    localparam logic [3:0] REG_SUB_RESET = 4'd8;
    localparam logic [3:0] REG_IRQ_ACK   = 4'd9;
    localparam logic [3:0] REG_FIRQ_ACK  = 4'd10;

    typedef logic [ 8:0] bank_t;
    typedef logic [21:0] phys_addr_t;

    localparam bank_t      VECTOR_BANK   = 9'h1FF;  // top window reads land here
    localparam logic [7:0] OPEN_BUS_DATA = 8'hFF;

    // region of the physical address, from its top bits
    typedef enum logic [1:0] {
        REGION_OPEN = 2'b00,
        REGION_RAM  = 2'b01,
        REGION_ROM  = 2'b10
    } region_t;

endpackage

`default_nettype wire

// File: hw/bank_mapper.sv
// per-CPU memory mapper
// eight 8 KB banks turn the 16-bit cpu address into a 22-bit physical one
// writes to the top window hit the mapper registers instead of the bus
// also keeps the irq/firq flags and, on the master, the sub cpu reset

`default_nettype none

module bank_mapper #(
    parameter bit MASTER = 1'b0     // only the master may drive sub_reset
) (
    input  wire                     clk,
    input  wire                     reset,
    input  shouse_pkg::cpu_bus_t    bus,
    input  wire                     commit,     // edge that ends this cpu's phase
    input  wire                     lvbl,
    input  wire                     firqn,
    output shouse_pkg::phys_addr_t  phys,
    output logic                    bus_req,
    output logic                    irq,
    output logic                    firq,
    output logic                    sub_reset
);
    import shouse_pkg::*;

    cpu_addr_u  addr_v;
    bank_t      bank_q [7];     // banks 0-6, bank 7 is the fixed window
    bank_t      sel_bank;
    logic       reg_wr;
    logic       wr_en;
    logic [6:0] bank_we;
    logic       srst_we;
    logic       irq_ack;
    logic       firq_ack;
    logic       lvbl_l;
    logic       firqn_l;
    logic       lvbl_fall;
    logic       firqn_fall;

    assign addr_v = bus.addr;

    // write into window 7 never reaches the bus
    assign reg_wr  = bus.vma && !bus.rnw && (addr_v.regs.window == 3'd7);
    assign bus_req = bus.vma && !reg_wr;
    assign wr_en   = commit && reg_wr;      // takes effect at phase end

    // bank lookup, window 7 reads go to the vector bank
    always_comb begin
        sel_bank = VECTOR_BANK;
        for (int i = 0; i < 7; i++) begin
            if (addr_v.mem.bank_sel == 3'(i)) sel_bank = bank_q[i];
        end
    end

    assign phys = {sel_bank, addr_v.mem.offset};

    // register index decode
    always_comb begin
        bank_we  = '0;
        srst_we  = 1'b0;
        irq_ack  = 1'b0;
        firq_ack = 1'b0;
        if (wr_en) begin
            case (addr_v.regs.reg_idx)
                REG_BANK0:     bank_we[0] = 1'b1;
                REG_BANK1:     bank_we[1] = 1'b1;
                REG_BANK2:     bank_we[2] = 1'b1;
                REG_BANK3:     bank_we[3] = 1'b1;
                REG_BANK4:     bank_we[4] = 1'b1;
                REG_BANK5:     bank_we[5] = 1'b1;
                REG_BANK6:     bank_we[6] = 1'b1;
                REG_SUB_RESET: srst_we    = MASTER;   // ignored on the sub
                REG_IRQ_ACK:   irq_ack    = 1'b1;
                REG_FIRQ_ACK:  firq_ack   = 1'b1;
                default:       ;                      // index 7, 11-15 do nothing
            endcase
        end
    end

    // bank registers, data byte low, address bit 0 as bank bit 8
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 7; i++) begin
                bank_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 7; i++) begin
                if (bank_we[i]) bank_q[i] <= {addr_v.regs.hi_bit, bus.dout};
            end
        end
    end

    // falling edge detectors for the interrupt sources
    assign lvbl_fall  = lvbl_l && !lvbl;
    assign firqn_fall = firqn_l && !firqn;

    always_ff @(posedge clk) begin
        if (reset) begin
            lvbl_l  <= 1'b0;    // low so no edge right out of reset
            firqn_l <= 1'b0;
        end else begin
            lvbl_l  <= lvbl;
            firqn_l <= firqn;
        end
    end

    // interrupt flags
    // a new edge wins over an ack in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            irq  <= 1'b0;
            firq <= 1'b0;
        end else begin
            irq  <= lvbl_fall  || (irq  && !irq_ack);
            firq <= firqn_fall || (firq && !firq_ack);
        end
    end

    // sub cpu held in reset until the master releases it
    always_ff @(posedge clk) begin
        if (reset) begin
            sub_reset <= 1'b1;
        end else if (srst_we) begin
            sub_reset <= ~bus.dout[0];  // bit 0 set = run
        end
    end

endmodule

`default_nettype wire

// File: hw/bus_phase.sv
// shared bus phase sequencer
// phase 0 is the master cpu, phase 1 the sub cpu
// each accepted cen3 ends the phase, pulses E or Q and latches read data
// the phase is frozen while the selected memory is busy

`default_nettype none

module bus_phase (
    input  wire         clk,
    input  wire         reset,
    input  wire         cen3,
    input  wire         busy,
    input  wire  [7:0]  bdin,
    output logic        bsel,       // 0 master, 1 sub
    output logic        cen_e,
    output logic        cen_q,
    output logic        m_commit,
    output logic        s_commit,
    output logic [7:0]  m_din,
    output logic [7:0]  s_din
);

    logic advance;

    // no cycle recovery, a blocked cen3 is simply lost
    assign advance  = cen3 && !busy;

    // phase end strobes, true during the cycle before the edge
    assign m_commit = advance && !bsel;
    assign s_commit = advance &&  bsel;

    // phase toggle and cpu enables
    always_ff @(posedge clk) begin
        if (reset) begin
            bsel  <= 1'b0;
            cen_e <= 1'b0;
            cen_q <= 1'b0;
        end else begin
            cen_e <= m_commit;          // one cycle wide
            cen_q <= s_commit;
            if (advance) bsel <= ~bsel;
        end
    end

    // read data held for the cpu whose phase just ended
    always_ff @(posedge clk) begin
        if (reset) begin
            m_din <= 8'd0;
            s_din <= 8'd0;
        end else begin
            if (m_commit) m_din <= bdin;
            if (s_commit) s_din <= bdin;
        end
    end

endmodule

`default_nettype wire

// File: hw/bus_decode.sv
// shared bus decoder
// physical address region into chip selects for both roms and the ram
// busy while a selected memory has not answered, plus read data mux

`default_nettype none

module bus_decode (
    input  wire                     bsel,
    input  wire                     bus_req,
    input  wire                     rnw,
    input  shouse_pkg::phys_addr_t  phys,
    input  wire                     mrom_ok,
    input  wire                     srom_ok,
    input  wire                     ram_ok,
    input  wire  [7:0]              mrom_data,
    input  wire  [7:0]              srom_data,
    input  wire  [7:0]              ram_dout,
    output logic                    mrom_cs,
    output logic                    srom_cs,
    output logic                    ram_cs,
    output logic                    busy,
    output logic [7:0]              bdin
);
    import shouse_pkg::*;

    region_t region;
    logic    rom_rd;

    // bit 21 alone picks rom, bit 20 splits ram from open space
    always_comb begin
        if (phys[21])      region = REGION_ROM;
        else if (phys[20]) region = REGION_RAM;
        else               region = REGION_OPEN;
    end

    // roms are read only, a write there selects nothing
    assign rom_rd  = bus_req && rnw && (region == REGION_ROM);
    assign mrom_cs = rom_rd && !bsel;       // each cpu has its own rom
    assign srom_cs = rom_rd &&  bsel;
    assign ram_cs  = bus_req && (region == REGION_RAM);

    // wait while any selected memory is not ready
    assign busy = (mrom_cs && !mrom_ok) ||
                  (srom_cs && !srom_ok) ||
                  (ram_cs  && !ram_ok);

    always_comb begin
        if (mrom_cs)      bdin = mrom_data;
        else if (srom_cs) bdin = srom_data;
        else if (ram_cs)  bdin = ram_dout;
        else              bdin = OPEN_BUS_DATA;  // open region, pulled up
    end

endmodule

`default_nettype wire

// File: hw/shouse_main.sv
// two-cpu memory mapper and shared bus sequencer
// each cpu gets its own bank mapper, one bus is shared in alternate phases
// the selected cpu's translated address and data drive the external bus

`default_nettype none

module shouse_main (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     cen3,
    input  wire                     lvbl,
    input  wire                     firqn,      // sets firq on both cpus
    input  shouse_pkg::cpu_bus_t    mbus,
    input  shouse_pkg::cpu_bus_t    sbus,
    input  wire                     mrom_ok,
    input  wire                     srom_ok,
    input  wire                     ram_ok,
    input  wire  [7:0]              mrom_data,
    input  wire  [7:0]              srom_data,
    input  wire  [7:0]              ram_dout,
    output logic [7:0]              m_din,
    output logic [7:0]              s_din,
    output logic                    cen_e,
    output logic                    cen_q,
    output logic                    m_irq,
    output logic                    m_firq,
    output logic                    s_irq,
    output logic                    s_firq,
    output logic                    sub_reset,
    output shouse_pkg::phys_addr_t  baddr,      // shared by both cpus
    output logic [7:0]              bdout,
    output logic                    brnw,
    output logic                    mrom_cs,
    output logic                    srom_cs,
    output logic                    ram_cs
);
    import shouse_pkg::*;

    phys_addr_t m_phys, s_phys;
    cpu_bus_t   sel_bus;
    logic       m_req, s_req, bus_req;
    logic       m_commit, s_commit;
    logic       bsel;                   // 0 master, 1 sub
    logic       busy;
    logic [7:0] bdin;

    // phase selected bus, purely combinational
    assign sel_bus = bsel ? sbus   : mbus;
    assign baddr   = bsel ? s_phys : m_phys;
    assign bus_req = bsel ? s_req  : m_req;
    assign bdout   = sel_bus.dout;
    assign brnw    = sel_bus.rnw;

    bank_mapper #(.MASTER(1'b1)) u_mmap (
        .clk        (clk),
        .reset      (reset),
        .bus        (mbus),
        .commit     (m_commit),
        .lvbl       (lvbl),
        .firqn      (firqn),
        .phys       (m_phys),
        .bus_req    (m_req),
        .irq        (m_irq),
        .firq       (m_firq),
        .sub_reset  (sub_reset)
    );

    bank_mapper #(.MASTER(1'b0)) u_smap (
        .clk        (clk),
        .reset      (reset),
        .bus        (sbus),
        .commit     (s_commit),
        .lvbl       (lvbl),
        .firqn      (firqn),
        .phys       (s_phys),
        .bus_req    (s_req),
        .irq        (s_irq),
        .firq       (s_firq),
        .sub_reset  ()              // sub cannot reset itself
    );

    bus_phase u_phase (
        .clk        (clk),
        .reset      (reset),
        .cen3       (cen3),
        .busy       (busy),
        .bdin       (bdin),
        .bsel       (bsel),
        .cen_e      (cen_e),
        .cen_q      (cen_q),
        .m_commit   (m_commit),
        .s_commit   (s_commit),
        .m_din      (m_din),
        .s_din      (s_din)
    );

    bus_decode u_decode (
        .bsel       (bsel),
        .bus_req    (bus_req),
        .rnw        (sel_bus.rnw),
        .phys       (baddr),
        .mrom_ok    (mrom_ok),
        .srom_ok    (srom_ok),
        .ram_ok     (ram_ok),
        .mrom_data  (mrom_data),
        .srom_data  (srom_data),
        .ram_dout   (ram_dout),
        .mrom_cs    (mrom_cs),
        .srom_cs    (srom_cs),
        .ram_cs     (ram_cs),
        .busy       (busy),
        .bdin       (bdin)
    );

endmodule

`default_nettype wire

// File: sim/tb_memory.sv
// memory responder for the shared bus testbench
// ok comes 0-3 cycles after a chip select rises, delay given per request
// read data is a pure function of the physical address

`default_nettype none

module tb_memory (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     cs,
    input  shouse_pkg::phys_addr_t  addr,
    input  wire  [1:0]              lat,        // wait for the next request
    output logic                    ok,
    output logic [7:0]              data
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [1:0] wait_cnt = 2'd0;
    logic       cs_seen  = 1'b0;
    logic       rst_seen = 1'b1;
    logic [1:0] lat_seen = 2'd0;

    assign ok   = (wait_cnt == 2'd0);       // ignored by the dut while cs is low
    assign data = addr[7:0] ^ addr[15:8];   // low byte xor the next one

    // sample at the falling edge, nothing moves there
    always @(negedge clk) begin
        cs_seen  = cs;
        rst_seen = reset;
        lat_seen = lat;
    end

    // count down just after the rising edge like the other inputs
    always @(posedge clk) begin
        #1;
        if (rst_seen) begin
            wait_cnt = 2'd0;
        end else if (!cs_seen) begin
            wait_cnt = lat_seen;            // idle, arm the next delay
        end else if (wait_cnt != 2'd0) begin
            wait_cnt = wait_cnt - 2'd1;
        end
    end

endmodule

`default_nettype wire

// File: sim/shouse_tb.sv
// testbench for the two-cpu mapper and shared bus sequencer
// lfsr driven cpu requests, three memory responders
// and a cycle model of phases, banks, flags and sub reset

`default_nettype none

module shouse_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import shouse_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 5;
    localparam int TEST_CYCLES  = 4000;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + TEST_CYCLES) * 6 * CLK_PERIOD;

    logic       clk = 1'b0;
    logic       reset;
    logic       cen3;
    logic       lvbl;
    logic       firqn;
    cpu_bus_t   mbus;
    cpu_bus_t   sbus;
    logic       mrom_ok, srom_ok, ram_ok;
    logic [7:0] mrom_data, srom_data, ram_dout;
    logic [1:0] mrom_lat, srom_lat, ram_lat;
    logic [7:0] m_din, s_din;
    logic       cen_e, cen_q, m_irq, m_firq, s_irq, s_firq, sub_reset;
    phys_addr_t baddr;
    logic [7:0] bdout;
    logic       brnw, mrom_cs, srom_cs, ram_cs;

    // model state indexed 0 for master and 1 for sub
    bank_t       mdl_bank [2][8];   // entry 7 unused
    logic [1:0]  mdl_irq, mdl_firq;
    logic        mdl_srst, mdl_bsel, mdl_cen_e, mdl_cen_q;
    logic [7:0]  mdl_m_din, mdl_s_din;
    logic        mdl_lvbl_l, mdl_firqn_l;
    logic [1:0]  phase_done;        // port may take a new request
    int          m_phases = 0;
    int          s_phases = 0;
    logic [31:0] lfsr = 32'h5025a53b;

    always #(CLK_PERIOD / 2) clk = ~clk;

    shouse_main shouse_main_inst (.*);

    tb_memory u_mrom (.clk(clk), .reset(reset), .cs(mrom_cs), .addr(baddr),
                      .lat(mrom_lat), .ok(mrom_ok), .data(mrom_data));
    tb_memory u_srom (.clk(clk), .reset(reset), .cs(srom_cs), .addr(baddr),
                      .lat(srom_lat), .ok(srom_ok), .data(srom_data));
    tb_memory u_ram  (.clk(clk), .reset(reset), .cs(ram_cs), .addr(baddr),
                      .lat(ram_lat), .ok(ram_ok), .data(ram_dout));

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic cpu_bus_t rand_req();
        cpu_bus_t r;
        r.addr = 16'(rand_bits(16));
        r.dout = 8'(rand_bits(8));
        r.rnw  = 1'(rand_bits(1));
        r.vma  = (rand_bits(2) != 0);
        if (rand_bits(2) == 0) begin     // extra register window writes
            r.addr[15:13] = 3'd7;
            r.rnw         = 1'b0;
        end
        return r;
    endfunction

    task automatic halt_on_failure();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_addr(input string name, input phys_addr_t got, input phys_addr_t want);
        if (got !== want) begin
            $display("Mismatch at %0d ns: %s got %h expected %h", $time, name, got, want);
            halt_on_failure();
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] want);
        if (got !== want) begin
            $display("Mismatch at %0d ns: %s got %h expected %h", $time, name, got, want);
            halt_on_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("Mismatch at %0d ns: %s got %b expected %b", $time, name, got, want);
            halt_on_failure();
        end
    endtask

    // new inputs 1 ns after the rising edge
    task automatic drive_inputs();
        cen3     = (rand_bits(2) != 0);
        lvbl     = (rand_bits(4) != 0);  // short low pulses now and then
        firqn    = (rand_bits(4) != 0);
        mrom_lat = 2'(rand_bits(2));
        srom_lat = 2'(rand_bits(2));
        ram_lat  = 2'(rand_bits(2));
        if (phase_done[0]) mbus = rand_req();
        if (phase_done[1]) sbus = rand_req();
        phase_done = 2'b00;
    endtask

    // compare at the falling edge then step the model over the next rising edge
    task automatic check_and_step();
        cpu_bus_t   p;
        logic       c, win7, reg_wr, req, rom, ram;
        logic       exp_m, exp_s, exp_r, busy, adv, fall_l, fall_f;
        logic [1:0] ack_i, ack_f;
        bank_t      bk;
        phys_addr_t ph;
        logic [7:0] rd;
        check_bit("cen_e", cen_e, mdl_cen_e);
        check_bit("cen_q", cen_q, mdl_cen_q);
        check_byte("m_din", m_din, mdl_m_din);
        check_byte("s_din", s_din, mdl_s_din);
        check_bit("m_irq", m_irq, mdl_irq[0]);
        check_bit("s_irq", s_irq, mdl_irq[1]);
        check_bit("m_firq", m_firq, mdl_firq[0]);
        check_bit("s_firq", s_firq, mdl_firq[1]);
        check_bit("sub_reset", sub_reset, mdl_srst);
        c      = mdl_bsel;
        p      = c ? sbus : mbus;
        win7   = (p.addr[15:13] == 3'd7);
        bk     = win7 ? VECTOR_BANK : mdl_bank[c][p.addr[15:13]];
        ph     = {bk, p.addr[12:0]};
        reg_wr = p.vma && !p.rnw && win7;      // never reaches the bus
        req    = p.vma && !reg_wr;
        rom    = ph[21];
        ram    = !ph[21] && ph[20];
        exp_m  = req && p.rnw && rom && !c;    // rom of the cpu in phase
        exp_s  = req && p.rnw && rom && c;
        exp_r  = req && ram;
        check_addr("baddr", baddr, ph);
        check_byte("bdout", bdout, p.dout);
        check_bit("brnw", brnw, p.rnw);
        check_bit("mrom_cs", mrom_cs, exp_m);
        check_bit("srom_cs", srom_cs, exp_s);
        check_bit("ram_cs", ram_cs, exp_r);
        busy  = (exp_m && !mrom_ok) || (exp_s && !srom_ok) || (exp_r && !ram_ok);
        rd    = (exp_m || exp_s || exp_r) ? (ph[7:0] ^ ph[15:8]) : OPEN_BUS_DATA;
        adv   = cen3 && !busy;                 // cen3 lost under back-pressure
        ack_i = 2'b00;
        ack_f = 2'b00;
        mdl_cen_e = adv && !c;
        mdl_cen_q = adv && c;
        if (adv) begin
            if (c) mdl_s_din = rd;
            else mdl_m_din = rd;
            if (reg_wr && p.addr[12:9] <= REG_BANK6) begin
                mdl_bank[c][p.addr[11:9]] = {p.addr[0], p.dout};
            end else if (reg_wr) begin
                case (p.addr[12:9])
                    REG_SUB_RESET: if (!c) mdl_srst = !p.dout[0];   // master only
                    REG_IRQ_ACK:   ack_i[c] = 1'b1;
                    REG_FIRQ_ACK:  ack_f[c] = 1'b1;
                    default:       ;
                endcase
            end
            if (c) s_phases++;
            else m_phases++;
            phase_done[c] = 1'b1;
            mdl_bsel      = !c;
        end
        fall_l      = mdl_lvbl_l && !lvbl;     // falling edge sets both cpus
        fall_f      = mdl_firqn_l && !firqn;
        mdl_irq     = {2{fall_l}} | (mdl_irq & ~ack_i);
        mdl_firq    = {2{fall_f}} | (mdl_firq & ~ack_f);
        mdl_lvbl_l  = lvbl;
        mdl_firqn_l = firqn;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog timeout, the test loop did not finish in time");
        halt_on_failure();
    end

    initial begin
        reset    = 1'b1;
        cen3     = 1'b0;
        lvbl     = 1'b1;
        firqn    = 1'b1;
        mbus     = '0;
        sbus     = '0;
        mrom_lat = 2'd0;
        srom_lat = 2'd0;
        ram_lat  = 2'd0;
        // model starts from the reset values
        for (int c = 0; c < 2; c++) begin
            for (int i = 0; i < 8; i++) mdl_bank[c][i] = '0;
        end
        mdl_irq     = 2'b00;
        mdl_firq    = 2'b00;
        mdl_srst    = 1'b1;
        mdl_bsel    = 1'b0;
        mdl_cen_e   = 1'b0;
        mdl_cen_q   = 1'b0;
        mdl_m_din   = 8'd0;
        mdl_s_din   = 8'd0;
        mdl_lvbl_l  = 1'b0;
        mdl_firqn_l = 1'b0;
        phase_done  = 2'b11;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        drive_inputs();
        repeat (TEST_CYCLES) begin
            @(negedge clk);
            check_and_step();
            @(posedge clk);
            #1;
            drive_inputs();
        end
        if (m_phases > 0 && s_phases > 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("No bus phase ended for one of the cpus");
            halt_on_failure();
        end
    end

endmodule

`default_nettype wire

// File: sources.f
hw/shouse_pkg.sv
hw/bank_mapper.sv
hw/bus_phase.sv
hw/bus_decode.sv
hw/shouse_main.sv
sim/tb_memory.sv
sim/shouse_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with verilator, run it, look for the pass line in the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG" build.log
verilator --binary --timing --timescale 1ns/100ps --top-module shouse_tb \
    -f sources.f -o shouse_sim > build.log 2>&1 \
    && ./obj_dir/shouse_sim > "$LOG" 2>&1 \
    || { cat build.log "$LOG" 2>/dev/null; echo "FAIL: build or run error"; exit 1; }
cat "$LOG"
grep -qx "Simulation completed successfully" "$LOG" && echo "PASS" \
    || { echo "FAIL"; exit 1; }
